// ==== Makefile ====
# Verilator build, run and lint for the router egress testbench

VERILATOR ?= verilator
TOP       ?= tb_router_egress
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= Test failed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported a failure"; exit 1; \
	elif [ $$status -ne 0 ]; then \
		echo "Simulation exited with status $$status"; exit 1; \
	else \
		echo "Simulation passed"; \
	fi

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== common/dq_note_if.sv ====
// Dequeue notification interface with source and sink modports

`timescale 1ns/1ps

interface dq_note_if
    import sched_pkg::*;
;

    logic       valid;
    logic       last;
    port_idx_t  port;
    queue_idx_t queue;
    data_t      data;

    // Driven by the queue buffer
    modport source (
        output valid, last, port, queue, data
    );

    // Watched by the scheduler for lock release
    modport sink (
        input valid, last, port, queue, data
    );

endinterface

// ==== common/sched_cfg.svh ====
// Egress scheduler configuration macros
// Port count, queues per port, queue depth, word width, dequeue latency

`ifndef SCHED_CFG_SVH
`define SCHED_CFG_SVH

// Number of egress ports
`define SCHED_NUM_PORTS 4

// Priority levels per port, higher index wins
`define SCHED_QUEUES_PER_PORT 4

// Words held by each queue
`define SCHED_QUEUE_DEPTH 8

// Packet word width
`define SCHED_DATA_W 8

// Cycles from dequeue request to notification
`define SCHED_DQ_LATENCY 2

`endif

// ==== common/sched_pkg.sv ====
// Shared scheduler types
// Index widths, notification word and pipeline stage enum

`include "sched_cfg.svh"

package sched_pkg;

    localparam int PORT_W     = $clog2(`SCHED_NUM_PORTS);
    localparam int QUEUE_W    = $clog2(`SCHED_QUEUES_PER_PORT);
    localparam int NUM_QUEUES = `SCHED_NUM_PORTS * `SCHED_QUEUES_PER_PORT;

    typedef logic [PORT_W-1:0]         port_idx_t;
    typedef logic [QUEUE_W-1:0]        queue_idx_t;
    // Port above priority
    typedef logic [PORT_W+QUEUE_W-1:0] gqueue_idx_t;
    typedef logic [`SCHED_DATA_W-1:0]  data_t;

    // One dequeued word with its origin
    typedef struct packed {
        logic       last;
        port_idx_t  port;
        queue_idx_t queue;
        data_t      data;
    } note_t;

    // Scheduler pipeline stage tags
    typedef enum logic [1:0] {
        IDLE     = 2'd0,
        SELECTED = 2'd1,
        ISSUE    = 2'd2
    } sched_state_e;

endpackage

// ==== compile.f ====
+incdir+common
common/sched_pkg.sv
common/dq_note_if.sv
hw/queue_buffer.sv
scheduler/egress_scheduler.sv
hw/router_egress_top.sv
tests/tb_router_egress.sv

// ==== hw/queue_buffer.sv ====
// Per-queue word FIFOs with enqueue and dequeue
// Fixed-latency dequeue notification pipeline

`timescale 1ns/1ps
`include "sched_cfg.svh"

module queue_buffer
    import sched_pkg::*;
(
    input  logic                  dequeue_notification,
    input  logic                  arst_n,
    input  logic                  enq_valid,
    input  gqueue_idx_t           enq_queue,
    input  data_t                 enq_data,
    input  logic                  enq_last,
    output logic                  enq_ready,
    output logic [NUM_QUEUES-1:0] queue_empty,
    input  logic                  deq_valid,
    input  port_idx_t             deq_port,
    input  queue_idx_t            deq_queue,
    dq_note_if.source             note
);

    localparam int DEPTH = `SCHED_QUEUE_DEPTH;
    localparam int LAT   = `SCHED_DQ_LATENCY;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    // Entry is {last, data}
    logic [`SCHED_DATA_W:0] mem [NUM_QUEUES][DEPTH];
    logic [PTR_W-1:0]       wr_ptr [NUM_QUEUES];
    logic [PTR_W-1:0]       rd_ptr [NUM_QUEUES];
    logic [CNT_W-1:0]       count [NUM_QUEUES];

    logic                   enq_fire;
    gqueue_idx_t            deq_gq;
    logic [NUM_QUEUES-1:0]  enq_hit;
    logic [NUM_QUEUES-1:0]  deq_hit;
    logic [`SCHED_DATA_W:0] head_entry;
    note_t                  head_note;
    note_t                  note_pipe [LAT];
    logic [LAT-1:0]         note_vld;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    //////////////////////////////
    // FIFO control
    //////////////////////////////

    assign enq_ready = (count[enq_queue] != CNT_W'(DEPTH));
    assign enq_fire  = enq_valid && enq_ready;
    assign deq_gq    = {deq_port, deq_queue};

    always_comb begin
        for (int g = 0; g < NUM_QUEUES; g++) begin
            enq_hit[g]     = enq_fire && (enq_queue == gqueue_idx_t'(g));
            deq_hit[g]     = deq_valid && (deq_gq == gqueue_idx_t'(g));
            queue_empty[g] = (count[g] == '0);
        end
    end

    always_ff @(posedge dequeue_notification or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '{default: '0};
            rd_ptr <= '{default: '0};
            count  <= '{default: '0};
        end else begin
            for (int g = 0; g < NUM_QUEUES; g++) begin
                if (enq_hit[g]) begin
                    wr_ptr[g] <= ptr_inc(wr_ptr[g]);
                end
                if (deq_hit[g]) begin
                    rd_ptr[g] <= ptr_inc(rd_ptr[g]);
                end
                // Simultaneous push and pop leaves the count alone
                if (enq_hit[g] && !deq_hit[g]) begin
                    count[g] <= count[g] + CNT_W'(1);
                end else if (!enq_hit[g] && deq_hit[g]) begin
                    count[g] <= count[g] - CNT_W'(1);
                end
            end
        end
    end

    always_ff @(posedge dequeue_notification) begin
        if (enq_fire) begin
            mem[enq_queue][wr_ptr[enq_queue]] <= {enq_last, enq_data};
        end
    end

    //////////////////////////////
    // Notification pipeline
    //////////////////////////////

    assign head_entry = mem[deq_gq][rd_ptr[deq_gq]];

    always_comb begin
        head_note.last  = head_entry[`SCHED_DATA_W];
        head_note.port  = deq_port;
        head_note.queue = deq_queue;
        head_note.data  = head_entry[`SCHED_DATA_W-1:0];
    end

    always_ff @(posedge dequeue_notification or negedge arst_n) begin
        if (!arst_n) begin
            note_vld <= '0;
        end else begin
            note_vld[0] <= deq_valid;
            for (int s = 1; s < LAT; s++) begin
                note_vld[s] <= note_vld[s-1];
            end
        end
    end

    always_ff @(posedge dequeue_notification) begin
        note_pipe[0] <= head_note;
        for (int s = 1; s < LAT; s++) begin
            note_pipe[s] <= note_pipe[s-1];
        end
    end

    assign note.valid = note_vld[LAT-1];
    assign note.last  = note_pipe[LAT-1].last;
    assign note.port  = note_pipe[LAT-1].port;
    assign note.queue = note_pipe[LAT-1].queue;
    assign note.data  = note_pipe[LAT-1].data;

    // Scheduler must only pick queues that hold a word
    a_deq_not_empty: assert property (@(posedge dequeue_notification) disable iff (!arst_n)
        deq_valid |-> !queue_empty[deq_gq]);

    // Count agrees with the distance between the pointers
    for (genvar g = 0; g < NUM_QUEUES; g++) begin : gen_cnt_chk
        a_cnt_ptr: assert property (@(posedge dequeue_notification) disable iff (!arst_n)
            (int'(count[g]) % DEPTH) ==
                ((int'(wr_ptr[g]) - int'(rd_ptr[g]) + DEPTH) % DEPTH));
    end

endmodule

// ==== hw/router_egress_top.sv ====
// Router egress top level
// Queue buffer, scheduler and egress output from the notification

`timescale 1ns/1ps
`include "sched_cfg.svh"

module router_egress_top
    import sched_pkg::*;
(
    input  logic                        dequeue_notification,
    input  logic                        arst_n,
    input  logic                        enq_valid,
    input  gqueue_idx_t                 enq_queue,
    input  data_t                       enq_data,
    input  logic                        enq_last,
    output logic                        enq_ready,
    input  logic [`SCHED_NUM_PORTS-1:0] egr_buf_ready,
    output logic                        egr_valid,
    output port_idx_t                   egr_port,
    output queue_idx_t                  egr_queue,
    output data_t                       egr_data,
    output logic                        egr_last
);

    logic [NUM_QUEUES-1:0] queue_empty;
    logic                  deq_valid;
    port_idx_t             deq_port;
    queue_idx_t            deq_queue;

    dq_note_if note_i ();

    queue_buffer buffer_i (
        .dequeue_notification (dequeue_notification),
        .arst_n               (arst_n),
        .enq_valid            (enq_valid),
        .enq_queue            (enq_queue),
        .enq_data             (enq_data),
        .enq_last             (enq_last),
        .enq_ready            (enq_ready),
        .queue_empty          (queue_empty),
        .deq_valid            (deq_valid),
        .deq_port             (deq_port),
        .deq_queue            (deq_queue),
        .note                 (note_i.source)
    );

    egress_scheduler scheduler_i (
        .dequeue_notification (dequeue_notification),
        .arst_n               (arst_n),
        .queue_empty          (queue_empty),
        .egr_buf_ready        (egr_buf_ready),
        .note                 (note_i.sink),
        .deq_valid            (deq_valid),
        .deq_port             (deq_port),
        .deq_queue            (deq_queue)
    );

    // Notification doubles as the egress stream
    assign egr_valid = note_i.valid;
    assign egr_port  = note_i.port;
    assign egr_queue = note_i.queue;
    assign egr_data  = note_i.data;
    assign egr_last  = note_i.last;

endmodule

// ==== scheduler/egress_scheduler.sv ====
// Egress scheduler with round-robin port pick
// and strict-priority, packet-atomic queue pick

`timescale 1ns/1ps
`include "sched_cfg.svh"

module egress_scheduler
    import sched_pkg::*;
(
    input  logic                        dequeue_notification,
    input  logic                        arst_n,
    input  logic [NUM_QUEUES-1:0]       queue_empty,
    input  logic [`SCHED_NUM_PORTS-1:0] egr_buf_ready,
    dq_note_if.sink                     note,
    output logic                        deq_valid,
    output port_idx_t                   deq_port,
    output queue_idx_t                  deq_queue
);

    localparam int NP  = `SCHED_NUM_PORTS;
    localparam int QPP = `SCHED_QUEUES_PER_PORT;
    localparam int LAT = `SCHED_DQ_LATENCY;

    logic [NP-1:0]  release_hit;
    logic [NP-1:0]  port_has_data;
    logic [NP-1:0]  port_busy;
    logic [LAT:0]   inflight [NP];
    logic [NP-1:0]  pkt_lock;
    queue_idx_t     active_queue [NP];

    port_idx_t      rr_ptr;
    logic           pick_valid;
    port_idx_t      pick_port;
    sched_state_e   sel_state_q;
    port_idx_t      sel_port_q;

    queue_idx_t     pick_queue;
    logic           pick_queue_ok;
    sched_state_e   iss_state_q;
    port_idx_t      iss_port_q;
    queue_idx_t     iss_queue_q;

    //////////////////////////////
    // Port status
    //////////////////////////////

    always_comb begin
        for (int p = 0; p < NP; p++) begin
            release_hit[p] = note.valid && note.last && (note.port == port_idx_t'(p));
            port_busy[p]   = |inflight[p];
            // A locked port only has data when its locked queue does
            if (pkt_lock[p] && !release_hit[p]) begin
                port_has_data[p] = !queue_empty[p*QPP + int'(active_queue[p])];
            end else begin
                port_has_data[p] = !(&queue_empty[p*QPP +: QPP]);
            end
        end
    end

    //////////////////////////////
    // Stage 1 port selection
    //////////////////////////////

    always_comb begin : rr_search
        int cand;
        pick_valid = 1'b0;
        pick_port  = '0;
        for (int i = 0; i < NP; i++) begin
            cand = (int'(rr_ptr) + i) % NP;
            if (!pick_valid && port_has_data[cand] && !port_busy[cand] && egr_buf_ready[cand]) begin
                pick_valid = 1'b1;
                pick_port  = port_idx_t'(cand);
            end
        end
    end

    always_ff @(posedge dequeue_notification or negedge arst_n) begin
        if (!arst_n) begin
            rr_ptr      <= '0;
            sel_state_q <= IDLE;
            sel_port_q  <= '0;
            inflight    <= '{default: '0};
        end else begin
            sel_state_q <= pick_valid ? SELECTED : IDLE;
            if (pick_valid) begin
                sel_port_q <= pick_port;
                rr_ptr     <= port_idx_t'((int'(pick_port) + 1) % NP);
            end
            // Port stays blocked until its notification is back
            for (int p = 0; p < NP; p++) begin
                inflight[p] <= {inflight[p][LAT-1:0], pick_valid && (pick_port == port_idx_t'(p))};
            end
        end
    end

    //////////////////////////////
    // Stage 2 queue selection
    //////////////////////////////

    always_comb begin : prio_pick
        pick_queue    = '0;
        pick_queue_ok = 1'b0;
        if (pkt_lock[sel_port_q]) begin
            pick_queue    = active_queue[sel_port_q];
            pick_queue_ok = !queue_empty[{sel_port_q, active_queue[sel_port_q]}];
        end else begin
            for (int q = QPP - 1; q >= 0; q--) begin
                if (!pick_queue_ok && !queue_empty[{sel_port_q, queue_idx_t'(q)}]) begin
                    pick_queue    = queue_idx_t'(q);
                    pick_queue_ok = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge dequeue_notification or negedge arst_n) begin
        if (!arst_n) begin
            iss_state_q  <= IDLE;
            iss_port_q   <= '0;
            iss_queue_q  <= '0;
            pkt_lock     <= '0;
            active_queue <= '{default: '0};
        end else begin
            for (int p = 0; p < NP; p++) begin
                if (release_hit[p]) begin
                    pkt_lock[p] <= 1'b0;
                end
            end
            iss_state_q <= IDLE;
            if (sel_state_q == SELECTED && pick_queue_ok) begin
                iss_state_q <= ISSUE;
                iss_port_q  <= sel_port_q;
                iss_queue_q <= pick_queue;
                // New packet takes the lock for this port
                if (!pkt_lock[sel_port_q]) begin
                    pkt_lock[sel_port_q]     <= 1'b1;
                    active_queue[sel_port_q] <= pick_queue;
                end
            end
        end
    end

    assign deq_valid = (iss_state_q == ISSUE);
    assign deq_port  = iss_port_q;
    assign deq_queue = iss_queue_q;

    // A port never gets a second request before its notification is back
    for (genvar k = 1; k <= LAT; k++) begin : gen_spacing_chk
        a_one_outstanding: assert property (@(posedge dequeue_notification) disable iff (!arst_n)
            deq_valid && $past(deq_valid, k) |-> (deq_port != $past(deq_port, k)));
    end

    a_lock_not_empty: assert property (@(posedge dequeue_notification) disable iff (!arst_n)
        (sel_state_q == SELECTED) && pkt_lock[sel_port_q]
            |-> !queue_empty[{sel_port_q, active_queue[sel_port_q]}]);

endmodule

// ==== tests/tb_router_egress.sv ====
// Directed testbench for the router egress top level
// Clock, reset, queue reference model, egress monitor and tests

`timescale 1ns/1ps
`include "sched_cfg.svh"

module tb_router_egress
    import sched_pkg::*;
;

    localparam int NP    = `SCHED_NUM_PORTS;
    localparam int DEPTH = `SCHED_QUEUE_DEPTH;
    localparam int LIMIT = 200;

    logic          dequeue_notification;
    logic          arst_n;
    logic          enq_valid;
    gqueue_idx_t   enq_queue;
    data_t         enq_data;
    logic          enq_last;
    logic          enq_ready;
    logic [NP-1:0] egr_buf_ready;
    logic          egr_valid;
    port_idx_t     egr_port;
    queue_idx_t    egr_queue;
    data_t         egr_data;
    logic          egr_last;

    // Reference words are {last, data} in one queue per global queue
    logic [`SCHED_DATA_W:0] ref_q [NUM_QUEUES][$];
    note_t                  seen [$];
    int                     errors;
    int                     err_mark;
    int                     tests_run;
    int                     tests_failed;

    router_egress_top dut_i (
        .dequeue_notification (dequeue_notification),
        .arst_n               (arst_n),
        .enq_valid            (enq_valid),
        .enq_queue            (enq_queue),
        .enq_data             (enq_data),
        .enq_last             (enq_last),
        .enq_ready            (enq_ready),
        .egr_buf_ready        (egr_buf_ready),
        .egr_valid            (egr_valid),
        .egr_port             (egr_port),
        .egr_queue            (egr_queue),
        .egr_data             (egr_data),
        .egr_last             (egr_last)
    );

    always #10 dequeue_notification = ~dequeue_notification;

    // Egress words land here and are matched against the reference queues
    always @(negedge dequeue_notification) begin : egress_monitor
        note_t                  w;
        logic [`SCHED_DATA_W:0] want;
        if (arst_n && egr_valid) begin
            w.last  = egr_last;
            w.port  = egr_port;
            w.queue = egr_queue;
            w.data  = egr_data;
            seen.push_back(w);
            if (ref_q[{egr_port, egr_queue}].size() == 0) begin
                $display("Egress word from port %0d queue %0d was never enqueued",
                         egr_port, egr_queue);
                errors++;
            end else begin
                want = ref_q[{egr_port, egr_queue}].pop_front();
                if (egr_data !== want[`SCHED_DATA_W-1:0]) begin
                    report_mismatch("egr_data", 32'(want[`SCHED_DATA_W-1:0]), 32'(egr_data));
                end
                if (egr_last !== want[`SCHED_DATA_W]) begin
                    report_mismatch("egr_last", 32'(want[`SCHED_DATA_W]), 32'(egr_last));
                end
            end
        end
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////

    task automatic report_mismatch(input string sig, input logic [31:0] want,
                                   input logic [31:0] got);
        $display("Error: %s expected 0x%0h got 0x%0h", sig, want, got);
        errors++;
    endtask

    // Holds valid until the word is accepted at the next rising edge
    task automatic enqueue_word(input gqueue_idx_t gq, input data_t data, input logic last);
        int waited;
        waited = 0;
        @(negedge dequeue_notification);
        enq_valid = 1'b1;
        enq_queue = gq;
        enq_data  = data;
        enq_last  = last;
        #1;
        while (!enq_ready && waited < LIMIT) begin
            @(negedge dequeue_notification);
            #1;
            waited++;
        end
        if (enq_ready) begin
            ref_q[gq].push_back({last, data});
        end else begin
            $display("Queue %0d never accepted an enqueue", gq);
            errors++;
        end
    endtask

    task automatic enqueue_packet(input gqueue_idx_t gq, input int len);
        for (int i = 0; i < len; i++) begin
            enqueue_word(gq, data_t'($urandom), i == len - 1);
        end
        @(negedge dequeue_notification);
        enq_valid = 1'b0;
    endtask

    task automatic wait_words(input int n);
        int waited;
        waited = 0;
        while (seen.size() < n && waited < LIMIT) begin
            @(posedge dequeue_notification);
            waited++;
        end
        if (seen.size() < n) begin
            $display("Timed out with %0d of %0d egress words", seen.size(), n);
            errors++;
        end
    endtask

    task automatic start_test();
        err_mark = errors;
        seen.delete();
    endtask

    task automatic finish_test(input string name);
        repeat (4) @(negedge dequeue_notification);
        for (int g = 0; g < NUM_QUEUES; g++) begin
            if (ref_q[g].size() != 0) begin
                $display("Queue %0d still holds %0d undelivered words", g, ref_q[g].size());
                errors++;
            end
        end
        tests_run++;
        if (errors == err_mark) begin
            $display("%s: PASS", name);
        end else begin
            tests_failed++;
            $display("%s: FAIL with %0d errors", name, errors - err_mark);
        end
    endtask

    //////////////////////////////
    // Directed tests
    //////////////////////////////

    task automatic test_reset_state();
        start_test();
        @(negedge dequeue_notification);
        #1;
        if (enq_ready !== 1'b1) report_mismatch("enq_ready", 32'(1), 32'(enq_ready));
        if (egr_valid !== 1'b0) report_mismatch("egr_valid", 32'(0), 32'(egr_valid));
        finish_test("reset state");
    endtask

    task automatic test_single_packet();
        data_t words [3];
        start_test();
        for (int i = 0; i < 3; i++) begin
            words[i] = data_t'($urandom);
        end
        for (int i = 0; i < 3; i++) begin
            enqueue_word({port_idx_t'(1), queue_idx_t'(2)}, words[i], i == 2);
        end
        @(negedge dequeue_notification);
        enq_valid = 1'b0;
        wait_words(3);
        for (int i = 0; i < 3 && i < seen.size(); i++) begin
            if (seen[i].data !== words[i]) begin
                report_mismatch("egr_data", 32'(words[i]), 32'(seen[i].data));
            end
            if (seen[i].port !== port_idx_t'(1)) begin
                report_mismatch("egr_port", 32'(1), 32'(seen[i].port));
            end
            if (seen[i].queue !== queue_idx_t'(2)) begin
                report_mismatch("egr_queue", 32'(2), 32'(seen[i].queue));
            end
            if (seen[i].last !== (i == 2)) begin
                report_mismatch("egr_last", 32'(i == 2), 32'(seen[i].last));
            end
        end
        finish_test("single packet");
    endtask

    task automatic test_strict_priority();
        queue_idx_t want_q;
        start_test();
        @(negedge dequeue_notification);
        egr_buf_ready[0] = 1'b0;
        enqueue_packet({port_idx_t'(0), queue_idx_t'(0)}, 2);
        enqueue_packet({port_idx_t'(0), queue_idx_t'(3)}, 3);
        @(negedge dequeue_notification);
        egr_buf_ready[0] = 1'b1;
        wait_words(5);
        for (int i = 0; i < 5 && i < seen.size(); i++) begin
            want_q = (i < 3) ? queue_idx_t'(3) : queue_idx_t'(0);
            if (seen[i].queue !== want_q) begin
                report_mismatch("egr_queue", 32'(want_q), 32'(seen[i].queue));
            end
        end
        finish_test("strict priority");
    endtask

    task automatic test_packet_atomicity();
        queue_idx_t want_q;
        start_test();
        enqueue_packet({port_idx_t'(1), queue_idx_t'(0)}, 6);
        // High priority arrives once the long packet is under way
        wait_words(1);
        enqueue_packet({port_idx_t'(1), queue_idx_t'(3)}, 2);
        wait_words(8);
        for (int i = 0; i < 8 && i < seen.size(); i++) begin
            want_q = (i < 6) ? queue_idx_t'(0) : queue_idx_t'(3);
            if (seen[i].queue !== want_q) begin
                report_mismatch("egr_queue", 32'(want_q), 32'(seen[i].queue));
            end
        end
        finish_test("packet atomicity");
    endtask

    task automatic test_round_robin();
        logic [NP-1:0] first_round;
        start_test();
        @(negedge dequeue_notification);
        egr_buf_ready = '0;
        for (int p = 0; p < NP; p++) begin
            enqueue_packet({port_idx_t'(p), queue_idx_t'(1)}, 1);
            enqueue_packet({port_idx_t'(p), queue_idx_t'(1)}, 1);
        end
        @(negedge dequeue_notification);
        egr_buf_ready = '1;
        wait_words(2 * NP);
        first_round = '0;
        for (int i = 0; i < NP && i < seen.size(); i++) begin
            first_round[seen[i].port] = 1'b1;
        end
        if (first_round !== '1) begin
            $display("A port sent its second packet before every port sent its first");
            errors++;
        end
        finish_test("round robin");
    endtask

    task automatic test_back_pressure();
        start_test();
        @(negedge dequeue_notification);
        egr_buf_ready[2] = 1'b0;
        enqueue_packet({port_idx_t'(2), queue_idx_t'(1)}, 3);
        enqueue_packet({port_idx_t'(0), queue_idx_t'(2)}, 2);
        enqueue_packet({port_idx_t'(1), queue_idx_t'(0)}, 2);
        enqueue_packet({port_idx_t'(3), queue_idx_t'(3)}, 2);
        wait_words(6);
        // Port 2 must stay silent through a quiet window
        repeat (20) @(negedge dequeue_notification);
        if (seen.size() != 6) begin
            $display("Got %0d egress words while port 2 was held, expected 6", seen.size());
            errors++;
        end
        for (int i = 0; i < seen.size() && i < 6; i++) begin
            if (seen[i].port === port_idx_t'(2)) begin
                $display("Port 2 sent a word while its egress buffer was not ready");
                errors++;
            end
        end
        egr_buf_ready[2] = 1'b1;
        wait_words(9);
        for (int i = 6; i < 9 && i < seen.size(); i++) begin
            if (seen[i].port !== port_idx_t'(2)) begin
                report_mismatch("egr_port", 32'(2), 32'(seen[i].port));
            end
        end
        finish_test("back-pressure");
    endtask

    task automatic test_full_queue();
        gqueue_idx_t gq;
        start_test();
        gq = {port_idx_t'(3), queue_idx_t'(2)};
        @(negedge dequeue_notification);
        egr_buf_ready[3] = 1'b0;
        enqueue_packet(gq, DEPTH);
        @(negedge dequeue_notification);
        enq_queue = gq;
        #1;
        if (enq_ready !== 1'b0) report_mismatch("enq_ready", 32'(0), 32'(enq_ready));
        @(negedge dequeue_notification);
        egr_buf_ready[3] = 1'b1;
        wait_words(DEPTH);
        @(negedge dequeue_notification);
        #1;
        if (enq_ready !== 1'b1) report_mismatch("enq_ready", 32'(1), 32'(enq_ready));
        finish_test("full queue");
    endtask

    initial begin : main
        void'($urandom(45387));
        errors       = 0;
        err_mark     = 0;
        tests_run    = 0;
        tests_failed = 0;
        dequeue_notification = 1'b0;
        arst_n        = 1'b0;
        enq_valid     = 1'b0;
        enq_queue     = '0;
        enq_data      = '0;
        enq_last      = 1'b0;
        egr_buf_ready = '1;
        repeat (4) @(negedge dequeue_notification);
        arst_n = 1'b1;

        test_reset_state();
        test_single_packet();
        test_strict_priority();
        test_packet_atomicity();
        test_round_robin();
        test_back_pressure();
        test_full_queue();

        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
